/* common/wbuf_pkg.sv */
// ##################################################
// write buffer shared definitions
// line, entry and bus beat types, queue sizing
// and the drain engine state encoding
// ##################################################

package wbuf_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 16;
    localparam int WB_DEPTH   = 10;
    localparam int CNT_W      = 4;

    // one cache line, word 0 in the low bits
    typedef logic [LINE_WORDS*WORD_W-1:0] wb_line_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        wb_line_t          data;
    } wb_entry_t;

    typedef struct packed {
        logic     hit;
        wb_line_t data;
    } wb_query_rsp_t;

    // line currently owned by the drain engine
    typedef struct packed {
        logic      valid;
        wb_entry_t entry;
    } wb_inflight_t;

    // write address channel
    typedef struct packed {
        logic              awvalid;
        logic [ADDR_W-1:0] awaddr;
    } axi_aw_t;

    // write data channel
    typedef struct packed {
        logic              wvalid;
        logic [WORD_W-1:0] wdata;
        logic              wlast;
    } axi_w_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        ADDR = 2'd1,
        DATA = 2'd2,
        RESP = 2'd3
    } drain_state_e;

endpackage

/* source/wb_subsystem.sv */
// ##################################################
// write buffer subsystem top
// queue of evicted lines plus the memory drain engine
// ##################################################

`timescale 1ns/10ps

module wb_subsystem (
    input  logic                        clk,
    input  logic                        rstn,
    // cache insert
    input  wbuf_pkg::wb_entry_t         in_entry,
    input  logic                        in_valid,
    output logic                        in_ready,
    // lookup
    input  logic [wbuf_pkg::ADDR_W-1:0] query_addr,
    output wbuf_pkg::wb_query_rsp_t     query_rsp,
    input  logic                        dma_hold,
    // memory write bus
    output wbuf_pkg::axi_aw_t           aw,
    input  logic                        awready,
    output wbuf_pkg::axi_w_t            w,
    input  logic                        wready,
    input  logic                        bvalid,
    output logic                        bready,
    // status
    output logic [wbuf_pkg::CNT_W-1:0]  count
);

    import wbuf_pkg::*;

    wb_entry_t    oldest;
    logic         nonempty;
    logic         pop;
    wb_inflight_t inflight;

    write_buffer u_write_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .in_entry   (in_entry),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .dma_hold   (dma_hold),
        .pop        (pop),
        .inflight   (inflight),
        .oldest     (oldest),
        .nonempty   (nonempty),
        .count      (count),
        .query_addr (query_addr),
        .query_rsp  (query_rsp)
    );

    wb_axi_drain u_wb_axi_drain (
        .clk      (clk),
        .rstn     (rstn),
        .oldest   (oldest),
        .nonempty (nonempty),
        .pop      (pop),
        .inflight (inflight),
        .aw       (aw),
        .awready  (awready),
        .w        (w),
        .wready   (wready),
        .bvalid   (bvalid),
        .bready   (bready)
    );

endmodule

/* verification/tb_wb_subsystem.sv */
// ##################################################
// write buffer subsystem testbench
// directed tests against a queue model and a
// memory slave with lfsr driven stalls
// ##################################################

`timescale 1ns/10ps

module tb_wb_subsystem;

    import wbuf_pkg::*;

    // summed per test cycle budgets times four
    localparam int CYCLE_LIMIT = (10 + 120 + 100 + 300 + 40 + 1000) * 4;

    logic clk;
    logic rstn;
    wb_entry_t in_entry;
    logic in_valid;
    logic in_ready;
    logic [ADDR_W-1:0] query_addr;
    wb_query_rsp_t query_rsp;
    logic dma_hold;
    axi_aw_t aw;
    logic awready;
    axi_w_t w;
    logic wready;
    logic bvalid;
    logic bready;
    logic [CNT_W-1:0] count;

    // model of the queue and of the line on the bus
    wb_entry_t sent[$];
    wb_entry_t cur;
    wb_entry_t got;
    logic busy = 0;
    logic resp_wait = 0;
    logic resp_done = 0;
    int beat_idx = 0;
    int accepted = 0;
    int started = 0;
    int drained = 0;
    int stall_mode = 0;
    logic [31:0] lfsr = 32'h1348_e322;
    int value_errors = 0;
    int proto_errors = 0;
    int cycles = 0;

    wb_subsystem uut (
        .clk        (clk),
        .rstn       (rstn),
        .in_entry   (in_entry),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .query_addr (query_addr),
        .query_rsp  (query_rsp),
        .dma_hold   (dma_hold),
        .aw         (aw),
        .awready    (awready),
        .w          (w),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .count      (count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        wait (cycles >= CYCLE_LIMIT);
        $display("run stopped after %0d cycles, the tests did not finish", cycles);
        $display("TB FAILED");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    function automatic logic [ADDR_W-1:0] line_addr(input int n);
        return ADDR_W'(32'h4000_0000 + n * 64);
    endfunction

    function automatic wb_entry_t make_entry(input int n, input logic [ADDR_W-1:0] addr);
        wb_entry_t e;
        e.addr = addr;
        for (int k = 0; k < LINE_WORDS; k++) begin
            e.data[k*WORD_W +: WORD_W] = {n[15:0], 8'(k), 8'(n * 7 + k)};
        end
        return e;
    endfunction

    // newest queued line wins over the line on the bus
    function automatic wb_query_rsp_t model_query(input logic [ADDR_W-1:0] addr);
        wb_query_rsp_t r;
        r = '0;
        foreach (sent[i]) begin
            if (sent[i].addr == addr) begin
                r.hit  = 1'b1;
                r.data = sent[i].data;
            end
        end
        if (!r.hit && busy && (cur.addr == addr)) begin
            r.hit  = 1'b1;
            r.data = cur.data;
        end
        return r;
    endfunction

    task automatic check_bit(input string name, input logic got_v, input logic exp_v);
        if (got_v !== exp_v) begin
            value_errors++;
            $display("Error at %0t ns: %s = %b, expected %b", $time, name, got_v, exp_v);
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] got_v,
                               input logic [CNT_W-1:0] exp_v);
        if (got_v !== exp_v) begin
            value_errors++;
            $display("Error at %0t ns: %s = %0d, expected %0d", $time, name, got_v, exp_v);
        end
    endtask

    task automatic check_entry(input string name, input wb_entry_t got_v, input wb_entry_t exp_v);
        if (got_v !== exp_v) begin
            value_errors++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got_v, exp_v);
        end
    endtask

    task automatic check_query(input string name, input wb_query_rsp_t got_v,
                               input wb_query_rsp_t exp_v);
        if (got_v !== exp_v) begin
            value_errors++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got_v, exp_v);
        end
    endtask

    // track the DUT at the falling edge and drive the slave for the next edge
    task automatic tick();
        logic b;
        @(negedge clk);
        if (resp_done) begin
            busy = 1'b0;
            resp_done = 1'b0;
        end
        if (in_ready) begin
            sent.push_back(in_entry);
            accepted++;
        end
        if (aw.awvalid && !busy) begin
            busy = 1'b1;
            started++;
            beat_idx = 0;
            got = '0;
            if (sent.size() == 0) begin
                proto_errors++;
                $display("at %0t ns the drain engine started with no line queued", $time);
            end else begin
                cur = sent.pop_front();
            end
        end
        check_bit("bready", bready, resp_wait);
        check_count("count", count, CNT_W'(accepted - started));
        if (stall_mode == 2) begin
            random_bit(b);
            awready = b;
            random_bit(b);
            wready = b;
            random_bit(b);
            bvalid = resp_wait && b;
        end else begin
            awready = (stall_mode == 0);
            wready  = 1'b1;
            bvalid  = resp_wait;
        end
        // handshakes that the coming rising edge completes
        if (aw.awvalid && awready) got.addr = aw.awaddr;
        if (w.wvalid && wready) begin
            got.data[beat_idx*WORD_W +: WORD_W] = w.wdata;
            check_bit("w.wlast", w.wlast, beat_idx == LINE_WORDS - 1);
            if (beat_idx == LINE_WORDS - 1) begin
                check_entry("drained line", got, cur);
                drained++;
                resp_wait = 1'b1;
            end
            beat_idx++;
        end
        if (bvalid && bready) begin
            resp_wait = 1'b0;
            resp_done = 1'b1;
        end
    endtask

    task automatic insert_line(input wb_entry_t e);
        in_entry = e;
        in_valid = 1'b1;
        tick();
        while (!in_ready) tick();
        in_valid = 1'b0;
    endtask

    task automatic check_lookup(input logic [ADDR_W-1:0] addr);
        query_addr = addr;
        tick();
        check_query("query_rsp", query_rsp, model_query(addr));
    endtask

    task automatic wait_drained();
        while (busy || resp_wait || (sent.size() != 0)) tick();
    endtask

    task automatic test_reset();
        rstn = 1'b0;
        repeat (5) tick();
        rstn = 1'b1;
        tick();
        check_bit("in_ready", in_ready, 1'b0);
        check_bit("aw.awvalid", aw.awvalid, 1'b0);
        check_bit("w.wvalid", w.wvalid, 1'b0);
        check_bit("w.wlast", w.wlast, 1'b0);
        check_bit("bready", bready, 1'b0);
        check_lookup(line_addr(3));
    endtask

    task automatic test_query();
        stall_mode = 1;
        insert_line(make_entry(1, line_addr(100)));
        insert_line(make_entry(2, line_addr(101)));
        insert_line(make_entry(3, line_addr(101)));
        insert_line(make_entry(4, line_addr(102)));
        check_lookup(line_addr(101));
        check_lookup(line_addr(100));
        check_lookup(line_addr(102));
        check_lookup(line_addr(999));
        stall_mode = 0;
        wait_drained();
    endtask

    task automatic test_drain_order();
        for (int i = 0; i < 4; i++) begin
            insert_line(make_entry(10 + i, line_addr(10 + i)));
        end
        wait_drained();
    endtask

    task automatic test_full();
        stall_mode = 1;
        for (int i = 0; i <= WB_DEPTH; i++) begin
            insert_line(make_entry(20 + i, line_addr(20 + i)));
        end
        // queue is full behind the stalled line
        in_entry = make_entry(40, line_addr(40));
        in_valid = 1'b1;
        repeat (8) begin
            tick();
            check_bit("in_ready", in_ready, 1'b0);
        end
        in_valid = 1'b0;
        check_bit("aw.awvalid", aw.awvalid, 1'b1);
        check_count("count", count, CNT_W'(WB_DEPTH));
        check_lookup(line_addr(20));
        stall_mode = 0;
        wait_drained();
    endtask

    task automatic test_dma_hold();
        dma_hold = 1'b1;
        in_entry = make_entry(50, line_addr(50));
        in_valid = 1'b1;
        repeat (10) begin
            tick();
            check_bit("in_ready", in_ready, 1'b0);
        end
        dma_hold = 1'b0;
        while (!in_ready) tick();
        in_valid = 1'b0;
        wait_drained();
    endtask

    task automatic test_random();
        logic b0;
        logic b1;
        stall_mode = 2;
        for (int i = 0; i < 24; i++) begin
            random_bit(b0);
            random_bit(b1);
            repeat ({b1, b0}) tick();
            insert_line(make_entry(60 + i, line_addr(60 + i)));
        end
        wait_drained();
        stall_mode = 0;
    endtask

    initial begin
        rstn       = 1'b0;
        in_entry   = '0;
        in_valid   = 1'b0;
        query_addr = '0;
        dma_hold   = 1'b0;
        awready    = 1'b0;
        wready     = 1'b0;
        bvalid     = 1'b0;
        test_reset();
        test_query();
        test_drain_order();
        test_full();
        test_dma_hold();
        test_random();
        $display("value errors %0d, other errors %0d, lines drained %0d of %0d",
                 value_errors, proto_errors, drained, accepted);
        if ((value_errors + proto_errors == 0) && (drained == accepted)) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verification/wb_subsystem_properties.sv */
// ##################################################
// drain engine bus rules
// burst length, stall stability and pop strobe
// ##################################################

`timescale 1ns/10ps

module wb_subsystem_properties (
    input logic                   clk,
    input logic                   rstn,
    input logic                   pop,
    input wbuf_pkg::axi_aw_t      aw,
    input logic                   awready,
    input wbuf_pkg::axi_w_t       w,
    input logic                   wready
);

    import wbuf_pkg::*;

    // beats accepted so far in the current burst
    logic [4:0] beats_taken;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beats_taken <= '0;
        end else if (w.wvalid && wready) begin
            if (w.wlast) begin
                beats_taken <= '0;
            end else begin
                beats_taken <= beats_taken + 1'b1;
            end
        end
    end

    // last flag on the sixteenth beat of a burst and on no other
    wlast_on_final_beat: assert property (@(posedge clk) disable iff (!rstn)
        (w.wvalid && wready) |-> (w.wlast == (beats_taken == 5'(LINE_WORDS - 1))))
        else $error("wlast does not mark the sixteenth beat");

    aw_stable_in_stall: assert property (@(posedge clk) disable iff (!rstn)
        (aw.awvalid && !awready) |=> (aw.awvalid && $stable(aw.awaddr)))
        else $error("write address changed while stalled");

    w_stable_in_stall: assert property (@(posedge clk) disable iff (!rstn)
        (w.wvalid && !wready) |=> (w.wvalid && $stable(w.wdata) && $stable(w.wlast)))
        else $error("write data changed while stalled");

    // single cycle strobe that opens an address phase
    pop_starts_burst: assert property (@(posedge clk) disable iff (!rstn)
        pop |=> (!pop && aw.awvalid))
        else $error("pop did not start a single address phase");

endmodule

bind wb_axi_drain wb_subsystem_properties u_properties (
    .clk      (clk),
    .rstn     (rstn),
    .pop      (pop),
    .aw       (aw),
    .awready  (awready),
    .w        (w),
    .wready   (wready)
);

/* wb_subsystem.f */
common/wbuf_pkg.sv
write_buffer/write_buffer.sv
write_buffer/wb_axi_drain.sv
source/wb_subsystem.sv
verification/wb_subsystem_properties.sv
verification/tb_wb_subsystem.sv

/* write_buffer/wb_axi_drain.sv */
// ##################################################
// write buffer drain engine
// pops the oldest line and writes it to memory as
// an address phase, a 16 beat burst and a response
// ##################################################

`timescale 1ns/10ps

module wb_axi_drain (
    input  logic                   clk,
    input  logic                   rstn,
    // queue side
    input  wbuf_pkg::wb_entry_t    oldest,
    input  logic                   nonempty,
    output logic                   pop,
    output wbuf_pkg::wb_inflight_t inflight,
    // memory bus
    output wbuf_pkg::axi_aw_t      aw,
    input  logic                   awready,
    output wbuf_pkg::axi_w_t       w,
    input  logic                   wready,
    input  logic                   bvalid,
    output logic                   bready
);

    import wbuf_pkg::*;

    drain_state_e state;
    drain_state_e state_nxt;
    logic [3:0]   beat;
    logic         last_beat;
    wb_entry_t    line_q;

    assign pop       = (state == IDLE) && nonempty;
    assign last_beat = (beat == 4'(LINE_WORDS - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (nonempty) begin
                    state_nxt = ADDR;
                end
            end
            ADDR: begin
                if (awready) begin
                    state_nxt = DATA;
                end
            end
            DATA: begin
                if (wready && last_beat) begin
                    state_nxt = RESP;
                end
            end
            RESP: begin
                if (bvalid) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            beat  <= '0;
        end else begin
            state <= state_nxt;
            if (pop) begin
                beat <= '0;
            end else if ((state == DATA) && wready) begin
                beat <= beat + 1'b1;
            end
        end
    end

    // line captured on the pop edge, safe from a same-cycle insert
    always_ff @(posedge clk) begin
        if (pop) begin
            line_q <= oldest;
        end
    end

    assign inflight.valid = (state != IDLE);
    assign inflight.entry = line_q;

    // address phase
    always_comb begin
        aw = '0;
        if (state == ADDR) begin
            aw.awvalid = 1'b1;
            aw.awaddr  = line_q.addr;
        end
    end

    // data burst, low word first
    always_comb begin
        w = '0;
        if (state == DATA) begin
            w.wvalid = 1'b1;
            w.wdata  = line_q.data[beat*WORD_W +: WORD_W];
            w.wlast  = last_beat;
        end
    end

    assign bready = (state == RESP);

endmodule

/* write_buffer/write_buffer.sv */
// ##################################################
// write buffer queue
// shifting store of evicted lines, newest in slot 0,
// with insert control, pop of the oldest entry and a
// same-cycle lookup by line address
// ##################################################

`timescale 1ns/10ps

module write_buffer (
    input  logic                        clk,
    input  logic                        rstn,
    // insert port
    input  wbuf_pkg::wb_entry_t         in_entry,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic                        dma_hold,
    // drain side
    input  logic                        pop,
    input  wbuf_pkg::wb_inflight_t      inflight,
    output wbuf_pkg::wb_entry_t         oldest,
    output logic                        nonempty,
    output logic [wbuf_pkg::CNT_W-1:0]  count,
    // lookup
    input  logic [wbuf_pkg::ADDR_W-1:0] query_addr,
    output wbuf_pkg::wb_query_rsp_t     query_rsp
);

    import wbuf_pkg::*;

    typedef enum logic {
        INS_IDLE = 1'b0,
        INS_PUSH = 1'b1
    } ins_state_e;

    wb_entry_t        slots [WB_DEPTH];
    ins_state_e       ins_state;
    ins_state_e       ins_state_nxt;
    logic             accept;
    logic [CNT_W-1:0] oldest_idx;

    // insert needs room, no dma hold and an idle controller
    assign accept = in_valid && (count < CNT_W'(WB_DEPTH)) && !dma_hold
                    && (ins_state == INS_IDLE);

    always_comb begin
        case (ins_state)
            INS_IDLE: ins_state_nxt = accept ? INS_PUSH : INS_IDLE;
            INS_PUSH: ins_state_nxt = INS_IDLE;
            default:  ins_state_nxt = INS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ins_state <= INS_IDLE;
        end else begin
            ins_state <= ins_state_nxt;
        end
    end

    // acknowledge goes out the cycle after the entry is taken
    assign in_ready = (ins_state == INS_PUSH);

    // shift up on insert, slot 0 gets the new line
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < WB_DEPTH; i++) begin
                slots[i] <= '0;
            end
        end else if (accept) begin
            slots[0] <= in_entry;
            for (int i = 1; i < WB_DEPTH; i++) begin
                slots[i] <= slots[i-1];
            end
        end
    end

    // insert and pop together leave the count alone
    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
        end else begin
            if (accept && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !accept) begin
                count <= count - 1'b1;
            end
        end
    end

    assign nonempty   = (count != '0);
    assign oldest_idx = count - 1'b1;

    always_comb begin
        if (nonempty) begin
            oldest = slots[oldest_idx];
        end else begin
            oldest = '0;
        end
    end

    // lookup, walk from oldest to newest so the lowest slot wins
    always_comb begin
        query_rsp = '0;
        for (int i = WB_DEPTH - 1; i >= 0; i--) begin
            if ((CNT_W'(i) < count) && (slots[i].addr == query_addr)) begin
                query_rsp.hit  = 1'b1;
                query_rsp.data = slots[i].data;
            end
        end
        // then the line being written out
        if (!query_rsp.hit && inflight.valid && (inflight.entry.addr == query_addr)) begin
            query_rsp.hit  = 1'b1;
            query_rsp.data = inflight.entry.data;
        end
    end

endmodule
